// File: Makefile
SRCS := $(filter-out +%,$(shell cat flist.f))

obj_dir/Vrs_tb: flist.f $(SRCS) common/rs_consts.svh
	verilator --binary --top-module rs_tb -f flist.f

run: obj_dir/Vrs_tb
	./obj_dir/Vrs_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: common/dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

// Renamed instruction on its way from the map table into the station
interface dispatch_if import rs_pkg::*; ();

    logic      valid;
    alu_func_t func;
    tag_t      dest_tag;

    // Each source operand carries either a ready value or the tag to wait for
    tag_t      src_tag   [2];
    logic      src_ready [2];
    data_t     src_value [2];

    modport source (
        output valid,
        output func,
        output dest_tag,
        output src_tag,
        output src_ready,
        output src_value
    );

    modport sink (
        input valid,
        input func,
        input dest_tag,
        input src_tag,
        input src_ready,
        input src_value
    );

endinterface

`default_nettype wire

// File: common/rs_consts.svh
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// Architectural register count
`define RS_REG_COUNT   8

// Tag and operand widths
`define RS_TAG_WIDTH   4
`define RS_DATA_WIDTH  16

// One station entry per ALU
`define RS_FU_COUNT    2

// Tag value that marks a register with no pending producer
`define RS_ZERO_TAG    0

`endif

// File: common/rs_pkg.sv
`default_nettype none

`include "rs_consts.svh"

package rs_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // Operand or result value
    typedef logic [`RS_DATA_WIDTH-1:0] data_t;

    // Producer tag where zero means no producer
    typedef logic [`RS_TAG_WIDTH-1:0] tag_t;

    // Architectural register index
    typedef logic [$clog2(`RS_REG_COUNT)-1:0] reg_idx_t;

    // Station entry or ALU index
    typedef logic [$clog2(`RS_FU_COUNT)-1:0] fu_idx_t;

    ////////////////////////////////////////////////////////////
    // ALU functions
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_func_t;

endpackage

`default_nettype wire

// File: flist.f
+incdir+common
common/rs_pkg.sv
common/dispatch_if.sv
source/fu_alu.sv
rs/cdb_select.sv
rs/rs.sv
rename/map_table.sv
source/issue_top.sv
test/rs_tb.sv

// File: rename/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module map_table import rs_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       squash,
    input  logic       dispatch_valid,
    input  alu_func_t  dispatch_func,
    input  tag_t       dispatch_tag,
    input  reg_idx_t   src_reg [2],
    input  reg_idx_t   dest_reg,
    input  data_t      src_value [2],
    input  logic       rs_full,
    input  logic       cdb_valid,
    input  tag_t       cdb_tag,
    input  data_t      cdb_value,
    dispatch_if.source dispatch
);

    logic  map_valid [`RS_REG_COUNT];
    logic  map_ready [`RS_REG_COUNT];
    tag_t  map_tag   [`RS_REG_COUNT];
    data_t map_value [`RS_REG_COUNT];
    logic  cdb_hit   [`RS_REG_COUNT];
    logic  accept;

    // Refused dispatches never reach the station
    assign accept            = dispatch_valid && !rs_full;
    assign dispatch.valid    = accept;
    assign dispatch.func     = dispatch_func;
    assign dispatch.dest_tag = dispatch_tag;

    // Pending entries whose producer broadcasts this cycle
    always_comb begin
        for (int r = 0; r < `RS_REG_COUNT; r++) begin
            cdb_hit[r] = cdb_valid && map_valid[r] && !map_ready[r] && (map_tag[r] == cdb_tag);
        end
    end

    ////////////////////////////////////////////////////////////
    // Source lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (!map_valid[src_reg[i]]) begin
                // No producer so the value comes straight from the register file
                dispatch.src_tag[i]   = tag_t'(`RS_ZERO_TAG);
                dispatch.src_ready[i] = 1'b1;
                dispatch.src_value[i] = src_value[i];
            end else if (cdb_hit[src_reg[i]]) begin
                dispatch.src_tag[i]   = map_tag[src_reg[i]];
                dispatch.src_ready[i] = 1'b1;
                dispatch.src_value[i] = cdb_value;
            end else begin
                dispatch.src_tag[i]   = map_tag[src_reg[i]];
                dispatch.src_ready[i] = map_ready[src_reg[i]];
                dispatch.src_value[i] = map_value[src_reg[i]];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Map update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `RS_REG_COUNT; r++) begin
                map_valid[r] <= 1'b0;
                map_ready[r] <= 1'b0;
            end
        end else if (squash) begin
            for (int r = 0; r < `RS_REG_COUNT; r++) begin
                map_valid[r] <= 1'b0;
                map_ready[r] <= 1'b0;
            end
        end else begin
            for (int r = 0; r < `RS_REG_COUNT; r++) begin
                if (cdb_hit[r]) begin
                    map_ready[r] <= 1'b1;
                end
                // A rename of the same register overrides the broadcast
                if (accept && (dest_reg == reg_idx_t'(r))) begin
                    map_valid[r] <= 1'b1;
                    map_ready[r] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int r = 0; r < `RS_REG_COUNT; r++) begin
            if (accept && (dest_reg == reg_idx_t'(r))) begin
                map_tag[r] <= dispatch_tag;
            end
            if (cdb_hit[r]) begin
                map_value[r] <= cdb_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: rs/cdb_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module cdb_select import rs_pkg::*; (
    input  logic [`RS_FU_COUNT-1:0] done,
    output logic [`RS_FU_COUNT-1:0] grant,
    output logic                    any_grant
);

    fu_idx_t winner;

    // Fixed priority, lowest index wins
    always_comb begin
        winner = '0;
        for (int i = `RS_FU_COUNT - 1; i >= 0; i--) begin
            if (done[i]) begin
                winner = fu_idx_t'(i);
            end
        end
    end

    assign any_grant = |done;

    always_comb begin
        grant         = '0;
        grant[winner] = any_grant;
    end

endmodule

`default_nettype wire

// File: rs/rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs import rs_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     squash,
    dispatch_if.sink dispatch,
    output logic     rs_full,
    output logic     cdb_valid,
    output tag_t     cdb_tag,
    output data_t    cdb_value
);

    // Station entries
    logic [`RS_FU_COUNT-1:0] busy;
    alu_func_t               ent_func [`RS_FU_COUNT];
    tag_t                    ent_dest [`RS_FU_COUNT];
    tag_t                    op_tag   [`RS_FU_COUNT][2];
    logic                    op_ready [`RS_FU_COUNT][2];
    data_t                   op_value [`RS_FU_COUNT][2];

    logic                    wake     [`RS_FU_COUNT][2];
    logic [`RS_FU_COUNT-1:0] write;
    logic [`RS_FU_COUNT-1:0] issue;
    fu_idx_t                 alloc_idx;

    // ALU side
    logic [`RS_FU_COUNT-1:0] alu_done;
    logic [`RS_FU_COUNT-1:0] grant;
    data_t                   alu_result [`RS_FU_COUNT];
    tag_t                    alu_tag    [`RS_FU_COUNT];
    logic                    any_grant;

    assign rs_full = &busy;

    // Lowest free entry whenever the station has room
    always_comb begin
        alloc_idx = '0;
        for (int i = `RS_FU_COUNT - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_idx = fu_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_FU_COUNT; i++) begin
            write[i] = dispatch.valid && (alloc_idx == fu_idx_t'(i));
            // ALU may take a new op at the edge its old result leaves
            issue[i] = busy[i] && op_ready[i][0] && op_ready[i][1] &&
                       (!alu_done[i] || grant[i]);
            for (int j = 0; j < 2; j++) begin
                wake[i][j] = cdb_valid && busy[i] && !op_ready[i][j] &&
                             (op_tag[i][j] == cdb_tag);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < `RS_FU_COUNT; i++) begin
                op_ready[i][0] <= 1'b0;
                op_ready[i][1] <= 1'b0;
            end
        end else if (squash) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < `RS_FU_COUNT; i++) begin
                if (issue[i]) begin
                    busy[i] <= 1'b0;
                end
                for (int j = 0; j < 2; j++) begin
                    if (wake[i][j]) begin
                        op_ready[i][j] <= 1'b1;
                    end
                end
                if (write[i]) begin
                    busy[i]        <= 1'b1;
                    op_ready[i][0] <= dispatch.src_ready[0];
                    op_ready[i][1] <= dispatch.src_ready[1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_FU_COUNT; i++) begin
            for (int j = 0; j < 2; j++) begin
                if (wake[i][j]) begin
                    op_value[i][j] <= cdb_value;
                end
            end
            if (write[i]) begin
                ent_func[i] <= dispatch.func;
                ent_dest[i] <= dispatch.dest_tag;
                for (int j = 0; j < 2; j++) begin
                    op_tag[i][j]   <= dispatch.src_tag[j];
                    op_value[i][j] <= dispatch.src_value[j];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // ALUs and CDB
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `RS_FU_COUNT; i++) begin : g_alu
        fu_alu u_alu (
            .clock      (clock),
            .rst_n      (rst_n),
            .squash     (squash),
            .start      (issue[i]),
            .func       (ent_func[i]),
            .opa        (op_value[i][0]),
            .opb        (op_value[i][1]),
            .tag        (ent_dest[i]),
            .grant      (grant[i]),
            .done       (alu_done[i]),
            .result     (alu_result[i]),
            .result_tag (alu_tag[i])
        );
    end

    cdb_select u_cdb_select (
        .done      (alu_done),
        .grant     (grant),
        .any_grant (any_grant)
    );

    // Grant is one-hot, so the mux never sees two sources
    always_comb begin
        cdb_tag   = '0;
        cdb_value = '0;
        for (int i = 0; i < `RS_FU_COUNT; i++) begin
            if (grant[i]) begin
                cdb_tag   = alu_tag[i];
                cdb_value = alu_result[i];
            end
        end
    end

    assign cdb_valid = any_grant;

endmodule

`default_nettype wire

// File: source/fu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module fu_alu import rs_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      squash,
    input  logic      start,
    input  alu_func_t func,
    input  data_t     opa,
    input  data_t     opb,
    input  tag_t      tag,
    input  logic      grant,
    output logic      done,
    output data_t     result,
    output tag_t      result_tag
);

    data_t alu_out;

    always_comb begin
        case (func)
            ALU_ADD: alu_out = opa + opb;
            ALU_SUB: alu_out = opa - opb;
            ALU_AND: alu_out = opa & opb;
            ALU_OR:  alu_out = opa | opb;
            ALU_XOR: alu_out = opa ^ opb;
            ALU_SLT: alu_out = data_t'($signed(opa) < $signed(opb));
            default: alu_out = '0;
        endcase
    end

    // Result stays until the CDB takes it
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (squash) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result     <= alu_out;
            result_tag <= tag;
        end
    end

endmodule

`default_nettype wire

// File: source/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top import rs_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      squash,
    input  logic      dispatch_valid,
    input  alu_func_t dispatch_func,
    input  tag_t      dispatch_tag,
    input  reg_idx_t  src1_reg,
    input  reg_idx_t  src2_reg,
    input  reg_idx_t  dest_reg,
    input  data_t     src1_value,
    input  data_t     src2_value,
    output logic      rs_full,
    output logic      cdb_valid,
    output tag_t      cdb_tag,
    output data_t     cdb_value
);

    reg_idx_t src_reg   [2];
    data_t    src_value [2];

    assign src_reg[0]   = src1_reg;
    assign src_reg[1]   = src2_reg;
    assign src_value[0] = src1_value;
    assign src_value[1] = src2_value;

    dispatch_if u_dispatch ();

    // Rename stage that also listens to the CDB
    map_table u_map_table (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch_func  (dispatch_func),
        .dispatch_tag   (dispatch_tag),
        .src_reg        (src_reg),
        .dest_reg       (dest_reg),
        .src_value      (src_value),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .dispatch       (u_dispatch)
    );

    rs u_rs (
        .clock     (clock),
        .rst_n     (rst_n),
        .squash    (squash),
        .dispatch  (u_dispatch),
        .rs_full   (rs_full),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

`default_nettype wire

// File: test/rs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_tb import rs_pkg::*; ();

    localparam int TAG_COUNT   = 1 << `RS_TAG_WIDTH;
    localparam int CYCLE_LIMIT = 2000;

    logic      clock;
    logic      rst_n;
    logic      squash;
    logic      dispatch_valid;
    alu_func_t dispatch_func;
    tag_t      dispatch_tag;
    reg_idx_t  src1_reg;
    reg_idx_t  src2_reg;
    reg_idx_t  dest_reg;
    data_t     src1_value;
    data_t     src2_value;
    logic      rs_full;
    logic      cdb_valid;
    tag_t      cdb_tag;
    data_t     cdb_value;

    // Reference model with register file, rename map and per-tag scoreboard
    integer    seed = 30;
    int        cycles = 0;
    int        outstanding = 0;
    logic      full_seen;
    data_t     rf         [`RS_REG_COUNT];
    logic      m_valid    [`RS_REG_COUNT];
    tag_t      m_tag      [`RS_REG_COUNT];
    logic      sb_pending [TAG_COUNT];
    alu_func_t sb_func    [TAG_COUNT];
    logic      sb_dep     [TAG_COUNT][2];
    tag_t      sb_dep_tag [TAG_COUNT][2];
    data_t     sb_val     [TAG_COUNT][2];
    logic      bc_done    [TAG_COUNT];
    data_t     bc_val     [TAG_COUNT];

    issue_top u_dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch_func  (dispatch_func),
        .dispatch_tag   (dispatch_tag),
        .src1_reg       (src1_reg),
        .src2_reg       (src2_reg),
        .dest_reg       (dest_reg),
        .src1_value     (src1_value),
        .src2_value     (src2_value),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    always #4 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s: actual 0x%0h expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_on_error("Timeout, the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // Model
    ////////////////////////////////////////////////////////////

    // ALU function table with SLT as a two's complement compare
    function automatic data_t expect_result(alu_func_t f, data_t a, data_t b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + data_t'(1);
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: begin
                if (a[`RS_DATA_WIDTH-1] != b[`RS_DATA_WIDTH-1]) begin
                    return data_t'(a[`RS_DATA_WIDTH-1]);
                end
                return data_t'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    function automatic reg_idx_t pick_src(input int low, input int span);
        return reg_idx_t'(low + int'($unsigned($random(seed)) % span));
    endfunction

    // Sources are looked up before the destination is renamed
    task automatic record_dispatch(input alu_func_t f, input reg_idx_t d,
                                   input reg_idx_t s1, input reg_idx_t s2, input tag_t t);
        reg_idx_t r;
        sb_func[t] = f;
        for (int j = 0; j < 2; j++) begin
            r = (j == 0) ? s1 : s2;
            sb_dep[t][j]     = m_valid[r];
            sb_dep_tag[t][j] = m_tag[r];
            sb_val[t][j]     = rf[r];
        end
        sb_pending[t] = 1'b1;
        outstanding++;
        m_valid[d] = 1'b1;
        m_tag[d]   = t;
    endtask

    task automatic on_broadcast(input tag_t t, input data_t v);
        data_t a;
        data_t b;
        logic  order_ok;
        order_ok = 1'b1;
        for (int j = 0; j < 2; j++) begin
            if (sb_dep[t][j] && !bc_done[sb_dep_tag[t][j]]) begin
                order_ok = 1'b0;
            end
        end
        if (!sb_pending[t]) begin
            stop_on_error($sformatf("CDB carried tag 0x%0h with no instruction waiting for it",
                                    t));
        end else if (!order_ok) begin
            stop_on_error($sformatf("Result of tag 0x%0h arrived before its producer", t));
        end else begin
            a = sb_dep[t][0] ? bc_val[sb_dep_tag[t][0]] : sb_val[t][0];
            b = sb_dep[t][1] ? bc_val[sb_dep_tag[t][1]] : sb_val[t][1];
            check("cdb_value", 32'(v), 32'(expect_result(sb_func[t], a, b)));
            sb_pending[t] = 1'b0;
            bc_done[t]    = 1'b1;
            bc_val[t]     = v;
            outstanding--;
        end
    endtask

    // CDB is stable in the middle of the cycle
    always @(negedge clock) begin
        if (rst_n && cdb_valid) begin
            on_broadcast(cdb_tag, cdb_value);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers that start and end at a rising edge
    ////////////////////////////////////////////////////////////

    task automatic send(input alu_func_t f, input reg_idx_t d, input reg_idx_t s1,
                        input reg_idx_t s2, input tag_t t, input logic retry,
                        output logic accepted);
        dispatch_valid <= 1'b1;
        dispatch_func  <= f;
        dispatch_tag   <= t;
        dest_reg       <= d;
        src1_reg       <= s1;
        src2_reg       <= s2;
        src1_value     <= rf[s1];
        src2_value     <= rf[s2];
        @(negedge clock);
        full_seen = rs_full;
        accepted  = !rs_full;
        while (retry && !accepted) begin
            @(negedge clock);
            accepted = !rs_full;
        end
        @(posedge clock);
        if (accepted) begin
            record_dispatch(f, d, s1, s2, t);
        end
    endtask

    task automatic go_idle();
        dispatch_valid <= 1'b0;
    endtask

    task automatic pulse_squash();
        squash         <= 1'b1;
        dispatch_valid <= 1'b0;
        @(posedge clock);
        squash <= 1'b0;
        for (int r = 0; r < `RS_REG_COUNT; r++) begin
            m_valid[r] = 1'b0;
        end
        for (int t = 0; t < TAG_COUNT; t++) begin
            sb_pending[t] = 1'b0;
            bc_done[t]    = 1'b0;
        end
        outstanding = 0;
    endtask

    // Drain all results, then clear the map so tags can be reused
    task automatic finish_test();
        go_idle();
        while (outstanding != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        pulse_squash();
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic independent_ops();
        logic acc;
        for (int i = 0; i < 6; i++) begin
            send(alu_func_t'(i), 3'd7, pick_src(0, 7), pick_src(0, 7), tag_t'(i + 1), 1'b1, acc);
        end
        finish_test();
    endtask

    task automatic dependency_chain();
        logic acc;
        send(ALU_ADD, 3'd1, 3'd2, 3'd3, tag_t'(1), 1'b1, acc);
        for (int i = 1; i < 6; i++) begin
            send(alu_func_t'(i), 3'd1, 3'd1, pick_src(3, 4), tag_t'(i + 1), 1'b1, acc);
        end
        finish_test();
    endtask

    task automatic full_station();
        logic acc;
        send(ALU_ADD, 3'd1, 3'd2, 3'd3, tag_t'(1), 1'b1, acc);
        send(ALU_SUB, 3'd4, 3'd1, 3'd5, tag_t'(2), 1'b0, acc);
        check("rs_full", 32'(full_seen), 32'd0);
        send(ALU_XOR, 3'd5, 3'd1, 3'd6, tag_t'(3), 1'b0, acc);
        check("rs_full", 32'(full_seen), 32'd0);
        // Both entries hold consumers now
        send(ALU_OR, 3'd6, 3'd2, 3'd3, tag_t'(4), 1'b0, acc);
        check("rs_full", 32'(full_seen), 32'd1);
        finish_test();
    endtask

    task automatic cdb_conflict();
        logic acc;
        send(ALU_AND, 3'd1, 3'd2, 3'd3, tag_t'(1), 1'b1, acc);
        send(ALU_SLT, 3'd4, 3'd5, 3'd6, tag_t'(2), 1'b1, acc);
        finish_test();
    endtask

    task automatic squash_pending();
        logic acc;
        send(ALU_ADD, 3'd1, 3'd2, 3'd3, tag_t'(1), 1'b1, acc);
        send(ALU_SUB, 3'd4, 3'd1, 3'd5, tag_t'(2), 1'b0, acc);
        check("rs_full", 32'(full_seen), 32'd0);
        // Entry that still waits on tag 2 when squash arrives
        send(ALU_XOR, 3'd5, 3'd4, 3'd6, tag_t'(3), 1'b0, acc);
        check("rs_full", 32'(full_seen), 32'd0);
        pulse_squash();
        @(negedge clock);
        check("cdb_valid", 32'(cdb_valid), 32'd0);
        check("rs_full", 32'(rs_full), 32'd0);
        repeat (6) @(negedge clock);
        @(posedge clock);
        // Renamed registers read the register file again
        send(ALU_XOR, 3'd6, 3'd1, 3'd4, tag_t'(4), 1'b1, acc);
        finish_test();
    endtask

    initial begin
        clock          = 1'b0;
        rst_n          = 1'b0;
        squash         = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_func  = ALU_ADD;
        dispatch_tag   = '0;
        src1_reg       = '0;
        src2_reg       = '0;
        dest_reg       = '0;
        src1_value     = '0;
        src2_value     = '0;
        for (int r = 0; r < `RS_REG_COUNT; r++) begin
            rf[r]      = data_t'($random(seed));
            m_valid[r] = 1'b0;
        end
        for (int t = 0; t < TAG_COUNT; t++) begin
            sb_pending[t] = 1'b0;
            bc_done[t]    = 1'b0;
        end
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);

        independent_ops();
        dependency_chain();
        full_station();
        cdb_conflict();
        squash_pending();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
